/* run_sim.sh */
#!/usr/bin/env bash
# build the router testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_noc_router -o sim_tb \
  > build.log 2>&1 &&
  ./obj_dir/sim_tb > sim.log 2>&1 ||
  echo "build or run returned an error, see build.log and sim.log"
grep -qx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb.f */
verilog/noc_pkg.sv
verilog/xbar_if.sv
verilog/flit_fifo.sv
verilog/input_unit.sv
verilog/output_arbiter.sv
verilog/router_config.sv
verilog/noc_router.sv
verification/tb_noc_router.sv

/* verification/tb_noc_router.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_noc_router;

  localparam int              NUM_Q   = noc_pkg::NUM_PORTS * noc_pkg::NUM_PORTS;
  localparam int              TIMEOUT = 2000;
  localparam logic [31:0]     SEED    = 32'he81a_fe6e;
  localparam noc_pkg::coord_t LOCAL_X = 4'd5;
  localparam noc_pkg::coord_t LOCAL_Y = 4'd6;

  logic                                    clk;
  logic                                    rst;
  noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] rx_flit;
  noc_pkg::port_mask_t                     rx_rts;
  noc_pkg::port_mask_t                     rx_cts;
  noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] tx_flit;
  noc_pkg::port_mask_t                     tx_rts;
  noc_pkg::port_mask_t                     tx_dcts;
  logic [1:0]                              wb_adr;
  logic [31:0]                             wb_dat_w;
  logic [31:0]                             wb_dat_r;
  logic                                    wb_we;
  logic                                    wb_stb;
  logic                                    wb_cyc;
  logic                                    wb_ack;

  int                  errors;
  int                  timeouts;
  int                  flits;
  int                  tails;
  logic [31:0]         rng [noc_pkg::NUM_PORTS+1];
  noc_pkg::flit_t      exp_q [NUM_Q][$];
  noc_pkg::port_mask_t en_mask;
  noc_pkg::port_mask_t in_pkt;
  int                  pkt_src [noc_pkg::NUM_PORTS];

  noc_router dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // link and bus checks
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < noc_pkg::NUM_PORTS; g++) begin : g_link_chk
    a_tx_hold: assert property (@(posedge clk) disable iff (rst)
      (tx_rts[g] && !tx_dcts[g]) |=> (tx_rts[g] && $stable(tx_flit[g])))
      else report_mismatch($sformatf("output %0d tx changed under back-pressure", g));
    a_tx_off: assert property (@(posedge clk) disable iff (rst) !en_mask[g] |-> !tx_rts[g])
      else report_mismatch($sformatf("disabled output %0d raised tx_rts", g));
    a_cts_pulse: assert property (@(posedge clk) disable iff (rst) rx_cts[g] |=> !rx_cts[g])
      else report_mismatch($sformatf("rx_cts on input %0d held two cycles", g));
  end

  a_wb_ack: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
    else report_mismatch("wb_ack held two cycles");

  function automatic void report_mismatch(input string msg);
    errors++;
    $display("mismatch at %0t: %s", $time, msg);
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] next_rand(input int idx);
    rng[idx] = xorshift32(rng[idx]);
    return rng[idx];
  endfunction

  // x first, then y
  function automatic int expected_output(input noc_pkg::coord_t dx, input noc_pkg::coord_t dy);
    if (dx > LOCAL_X) return noc_pkg::PORT_E;
    if (dx < LOCAL_X) return noc_pkg::PORT_W;
    if (dy > LOCAL_Y) return noc_pkg::PORT_N;
    if (dy < LOCAL_Y) return noc_pkg::PORT_S;
    return noc_pkg::PORT_L;
  endfunction

  function automatic logic queues_empty();
    for (int q = 0; q < NUM_Q; q++) begin
      if (exp_q[q].size() != 0) begin
        return 1'b0;
      end
    end
    return in_pkt == '0;
  endfunction

  // bits 26:24 of every flit hold the source input
  function automatic void check_flit(input int o, input noc_pkg::flit_t f);
    int                  src;
    int                  qi;
    logic                known;
    noc_pkg::flit_kind_t kind;
    src   = int'(f[26:24]);
    qi    = src * noc_pkg::NUM_PORTS + o;
    kind  = f[31:30];
    known = src < noc_pkg::NUM_PORTS && exp_q[qi].size() != 0;
    flits++;
    assert (known) else report_mismatch($sformatf("output %0d got unexpected %h", o, f));
    if (known) begin
      assert (exp_q[qi][0] == f)
        else report_mismatch($sformatf("output %0d got %h, expected %h", o, f, exp_q[qi][0]));
      void'(exp_q[qi].pop_front());
    end
    if (kind == noc_pkg::KIND_HEADER) begin
      assert (!in_pkt[o]) else report_mismatch($sformatf("header inside packet on %0d", o));
      in_pkt[o]  = 1'b1;
      pkt_src[o] = src;
    end else begin
      assert (in_pkt[o] && pkt_src[o] == src)
        else report_mismatch($sformatf("output %0d interleaved two packets", o));
      if (kind == noc_pkg::KIND_TAIL) begin
        in_pkt[o] = 1'b0;
        tails++;
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  task automatic wb_access(input logic [1:0] adr, input logic we, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int n;
    wb_adr   = adr;
    wb_we    = we;
    wb_dat_w = wdat;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    n        = 0;
    while (!wb_ack && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    rdat = wb_dat_r;
    if (!wb_ack) begin
      timeouts++;
      $display("timeout: no wb_ack for offset %0d", adr);
    end else begin
      assert (n == 1) else report_mismatch($sformatf("wb_ack came after %0d cycles", n));
    end
    // classic cycle ends on the edge where the master sees ack
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic send_flit(input int p, input noc_pkg::flit_t f);
    int n;
    rx_flit[p] = f;
    rx_rts[p]  = 1'b1;
    n          = 0;
    while (!rx_cts[p] && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (rx_cts[p]) begin
      // the flit moves on this edge
      @(posedge clk);
      #1;
    end else begin
      timeouts++;
      $display("timeout: input %0d never raised rx_cts", p);
    end
    rx_rts[p] = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic send_packet(input int src, input noc_pkg::coord_t dx, input noc_pkg::coord_t dy,
                             input int nbody);
    noc_pkg::flit_t f;
    int             qi;
    qi = src * noc_pkg::NUM_PORTS + expected_output(dx, dy);
    for (int k = 0; k <= nbody + 1; k++) begin
      f = next_rand(src);
      if (k == 0) begin
        f[31:30] = noc_pkg::KIND_HEADER;
        f[7:0]   = {dx, dy};
      end else if (k == nbody + 1) begin
        f[31:30] = noc_pkg::KIND_TAIL;
      end else begin
        f[31:30] = noc_pkg::KIND_BODY;
      end
      f[29:27] = 3'd0;
      f[26:24] = 3'(src);
      f[23:16] = 8'(k);
      exp_q[qi].push_back(f);
      send_flit(src, f);
    end
  endtask

  task automatic port_traffic(input int src, input int npkts);
    logic [31:0] r;
    for (int n = 0; n < npkts; n++) begin
      r = next_rand(src);
      send_packet(src, r[7:4], r[3:0], int'(r[9:8]) % 3);
      repeat (int'(r[11:10])) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (!queues_empty() && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!queues_empty()) begin
      timeouts++;
      $display("timeout: packets still inside the router");
    end
  endtask

  // transfers are judged at the falling edge, where the link is stable
  always @(negedge clk) begin
    if (!rst) begin
      for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
        if (tx_rts[o] && tx_dcts[o]) begin
          check_flit(o, tx_flit[o]);
        end
      end
    end
  end

  // random back-pressure from the neighbours
  initial begin
    logic [31:0] r;
    forever begin
      @(posedge clk);
      #1;
      r       = next_rand(noc_pkg::NUM_PORTS);
      tx_dcts = r[4:0] | r[12:8];
    end
  end

  initial begin
    logic [31:0] rd;
    rst      = 1'b1;
    rx_flit  = '0;
    rx_rts   = '0;
    tx_dcts  = '0;
    wb_adr   = '0;
    wb_dat_w = '0;
    wb_we    = 1'b0;
    wb_stb   = 1'b0;
    wb_cyc   = 1'b0;
    en_mask  = '1;
    in_pkt   = '0;
    errors   = 0;
    timeouts = 0;
    flits    = 0;
    tails    = 0;
    for (int p = 0; p <= noc_pkg::NUM_PORTS; p++) begin
      rng[p] = xorshift32(SEED ^ 32'(p + 1));
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    assert (tx_rts == '0 && rx_cts == '0 && !wb_ack)
      else report_mismatch("handshake outputs not low after reset");
    wb_access(noc_pkg::REG_ENABLE, 1'b0, 32'd0, rd);
    assert (rd == 32'h1f) else report_mismatch($sformatf("REG_ENABLE reads %h", rd));
    wb_access(noc_pkg::REG_ADDR, 1'b0, 32'd0, rd);
    assert (rd == 32'd0) else report_mismatch($sformatf("REG_ADDR reads %h", rd));
    wb_access(noc_pkg::REG_ADDR, 1'b1, {24'd0, LOCAL_X, LOCAL_Y}, rd);
    wb_access(noc_pkg::REG_ADDR, 1'b0, 32'd0, rd);
    assert (rd == {24'd0, LOCAL_X, LOCAL_Y})
      else report_mismatch($sformatf("REG_ADDR reads back %h", rd));

    fork
      port_traffic(noc_pkg::PORT_L, 12);
      port_traffic(noc_pkg::PORT_N, 12);
      port_traffic(noc_pkg::PORT_E, 12);
      port_traffic(noc_pkg::PORT_W, 12);
      port_traffic(noc_pkg::PORT_S, 12);
    join
    wait_drain();

    // two inputs heading east at once
    fork
      send_packet(noc_pkg::PORT_L, 4'd9, LOCAL_Y, 3);
      send_packet(noc_pkg::PORT_S, 4'd12, 4'd1, 3);
    join
    wait_drain();

    // east output off, then back on
    wb_access(noc_pkg::REG_ENABLE, 1'b1, 32'h1b, rd);
    en_mask[noc_pkg::PORT_E] = 1'b0;
    send_packet(noc_pkg::PORT_W, 4'd10, 4'd2, 1);
    repeat (20) begin
      @(posedge clk);
      #1;
    end
    assert (exp_q[noc_pkg::PORT_W * noc_pkg::NUM_PORTS + noc_pkg::PORT_E].size() == 3)
      else report_mismatch("flits left through a disabled output");
    en_mask[noc_pkg::PORT_E] = 1'b1;
    wb_access(noc_pkg::REG_ENABLE, 1'b1, 32'h1f, rd);
    wait_drain();

    wb_access(noc_pkg::REG_COUNT, 1'b0, 32'd0, rd);
    assert (rd == 32'(tails))
      else report_mismatch($sformatf("REG_COUNT %0d, tails %0d", rd, tails));
    wb_access(noc_pkg::REG_COUNT, 1'b1, 32'd0, rd);
    wb_access(noc_pkg::REG_COUNT, 1'b0, 32'd0, rd);
    assert (rd == 32'd0) else report_mismatch($sformatf("REG_COUNT %0d after clear", rd));

    $display("errors %0d, timeouts %0d, flits %0d, packets %0d", errors, timeouts, flits, tails);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/flit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module flit_fifo (
  input  logic           clk,
  input  logic           rst,
  input  noc_pkg::flit_t in_flit,
  input  logic           in_rts,
  input  logic           pop,
  output logic           in_cts,
  output noc_pkg::flit_t head,
  output logic           valid
);

  noc_pkg::flit_t mem [noc_pkg::FIFO_DEPTH];

  logic [$clog2(noc_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(noc_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(noc_pkg::FIFO_DEPTH+1)-1:0] count;
  logic [$clog2(noc_pkg::FIFO_DEPTH+1)-1:0] count_next;
  logic wr;
  logic rd;

  assign wr    = in_rts && in_cts;
  assign rd    = pop && valid;
  assign valid = (count != '0);
  assign head  = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (wr && !rd) begin
      count_next = count + 1'b1;
    end else if (!wr && rd) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      in_cts <= 1'b0;
    end else begin
      count <= count_next;
      if (wr) begin
        wr_ptr <= (int'(wr_ptr) == noc_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd) begin
        rd_ptr <= (int'(rd_ptr) == noc_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // one-cycle cts pulse, only with room left after this cycle
      in_cts <= in_rts && !in_cts && (int'(count_next) < noc_pkg::FIFO_DEPTH);
    end
  end

  // grants come from the output arbiters
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> valid)
    else $error("flit_fifo: pop while empty");

  a_no_write_full: assert property (@(posedge clk) disable iff (rst)
    (in_rts && in_cts) |-> (int'(count) < noc_pkg::FIFO_DEPTH))
    else $error("flit_fifo: write while full");

endmodule

`default_nettype wire

/* verilog/input_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module input_unit #(
  parameter int PORT = 0
) (
  input  logic            clk,
  input  logic            rst,
  input  noc_pkg::flit_t  rx_flit,
  input  logic            rx_rts,
  input  noc_pkg::coord_t local_x,
  input  noc_pkg::coord_t local_y,
  output logic            rx_cts,
  xbar_if.in_side         xb
);

  noc_pkg::flit_t      fifo_head;
  logic                fifo_valid;
  logic                pop;
  noc_pkg::flit_kind_t kind;
  noc_pkg::coord_t     dest_x;
  noc_pkg::coord_t     dest_y;
  noc_pkg::port_mask_t route;
  noc_pkg::port_mask_t req_q;

  flit_fifo u_fifo (
    .clk     (clk),
    .rst     (rst),
    .in_flit (rx_flit),
    .in_rts  (rx_rts),
    .pop     (pop),
    .in_cts  (rx_cts),
    .head    (fifo_head),
    .valid   (fifo_valid)
  );

  // at most one output serves this input in a cycle
  always_comb begin
    pop = 1'b0;
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      pop = pop | xb.grant[o][PORT];
    end
  end

  assign kind   = fifo_head[31:30];
  assign dest_x = fifo_head[7:4];
  assign dest_y = fifo_head[3:0];

  // dimension order, x first
  always_comb begin
    route = '0;
    if (dest_x > local_x) begin
      route[noc_pkg::PORT_E] = 1'b1;
    end else if (dest_x < local_x) begin
      route[noc_pkg::PORT_W] = 1'b1;
    end else if (dest_y > local_y) begin
      route[noc_pkg::PORT_N] = 1'b1;
    end else if (dest_y < local_y) begin
      route[noc_pkg::PORT_S] = 1'b1;
    end else begin
      route[noc_pkg::PORT_L] = 1'b1;
    end
  end

  // request held from header until the tail leaves
  always_ff @(posedge clk) begin
    if (rst) begin
      req_q <= '0;
    end else if (pop && kind == noc_pkg::KIND_TAIL) begin
      req_q <= '0;
    end else if (req_q == '0 && fifo_valid && kind == noc_pkg::KIND_HEADER) begin
      req_q <= route;
    end
  end

  assign xb.head[PORT]  = fifo_head;
  assign xb.valid[PORT] = fifo_valid;
  assign xb.req[PORT]   = req_q;

endmodule

`default_nettype wire

/* verilog/noc_pkg.sv */
`default_nettype none

package noc_pkg;

  ////////////////////////////////////////////////////////////
  // flits and coordinates
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] flit_t;
  typedef logic [1:0]  flit_kind_t;
  typedef logic [3:0]  coord_t;
  typedef logic [4:0]  port_mask_t;

  // kind sits in bits 31:30, dest x in 7:4, dest y in 3:0 of a header
  localparam flit_kind_t KIND_HEADER = 2'd1;
  localparam flit_kind_t KIND_BODY   = 2'd2;
  localparam flit_kind_t KIND_TAIL   = 2'd3;

  ////////////////////////////////////////////////////////////
  // ports
  ////////////////////////////////////////////////////////////

  localparam int PORT_L    = 0;
  localparam int PORT_N    = 1;
  localparam int PORT_E    = 2;
  localparam int PORT_W    = 3;
  localparam int PORT_S    = 4;
  localparam int NUM_PORTS = 5;

  localparam int FIFO_DEPTH = 4;

  // wishbone word offsets
  localparam logic [1:0] REG_ADDR   = 2'd0;
  localparam logic [1:0] REG_ENABLE = 2'd1;
  localparam logic [1:0] REG_COUNT  = 2'd2;

  typedef enum logic [2:0] {
    ARB_IDLE,
    ARB_L,
    ARB_N,
    ARB_E,
    ARB_W,
    ARB_S
  } arb_state_t;

endpackage

`default_nettype wire

/* verilog/noc_router.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_router (
  input  logic                                     clk,
  input  logic                                     rst,

  // links, indexed by port
  input  noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0]  rx_flit,
  input  noc_pkg::port_mask_t                      rx_rts,
  output noc_pkg::port_mask_t                      rx_cts,
  output noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0]  tx_flit,
  output noc_pkg::port_mask_t                      tx_rts,
  input  noc_pkg::port_mask_t                      tx_dcts,

  // wishbone config
  input  logic [1:0]                               wb_adr,
  input  logic [31:0]                              wb_dat_w,
  output logic [31:0]                              wb_dat_r,
  input  logic                                     wb_we,
  input  logic                                     wb_stb,
  input  logic                                     wb_cyc,
  output logic                                     wb_ack
);

  noc_pkg::coord_t     local_x;
  noc_pkg::coord_t     local_y;
  noc_pkg::port_mask_t port_enable;
  noc_pkg::port_mask_t packet_done;

  xbar_if xb ();

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < noc_pkg::NUM_PORTS; g++) begin : g_port

    input_unit #(
      .PORT (g)
    ) u_in (
      .clk     (clk),
      .rst     (rst),
      .rx_flit (rx_flit[g]),
      .rx_rts  (rx_rts[g]),
      .local_x (local_x),
      .local_y (local_y),
      .rx_cts  (rx_cts[g]),
      .xb      (xb)
    );

    output_arbiter #(
      .PORT (g)
    ) u_out (
      .clk         (clk),
      .rst         (rst),
      .enable      (port_enable[g]),
      .tx_dcts     (tx_dcts[g]),
      .tx_flit     (tx_flit[g]),
      .tx_rts      (tx_rts[g]),
      .packet_done (packet_done[g]),
      .xb          (xb)
    );

  end

  ////////////////////////////////////////////////////////////
  // configuration
  ////////////////////////////////////////////////////////////

  router_config u_cfg (
    .clk         (clk),
    .rst         (rst),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_we       (wb_we),
    .wb_stb      (wb_stb),
    .wb_cyc      (wb_cyc),
    .packet_done (packet_done),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .local_x     (local_x),
    .local_y     (local_y),
    .port_enable (port_enable)
  );

endmodule

`default_nettype wire

/* verilog/output_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module output_arbiter #(
  parameter int PORT = 0
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           enable,
  input  logic           tx_dcts,
  output noc_pkg::flit_t tx_flit,
  output logic           tx_rts,
  output logic           packet_done,
  xbar_if.out_side       xb
);

  noc_pkg::arb_state_t state;
  noc_pkg::arb_state_t state_next;
  noc_pkg::port_mask_t req_in;
  noc_pkg::flit_kind_t kind;
  logic [2:0]          sel;
  logic                xfer;

  function automatic noc_pkg::arb_state_t port_state(input int p);
    case (p)
      noc_pkg::PORT_N: return noc_pkg::ARB_N;
      noc_pkg::PORT_E: return noc_pkg::ARB_E;
      noc_pkg::PORT_W: return noc_pkg::ARB_W;
      noc_pkg::PORT_S: return noc_pkg::ARB_S;
      default:         return noc_pkg::ARB_L;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // request collection and priority
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
      req_in[i] = xb.req[i][PORT];
    end
  end

  // idle scans like ARB_L, starting from local
  always_comb begin
    case (state)
      noc_pkg::ARB_N: sel = 3'(noc_pkg::PORT_N);
      noc_pkg::ARB_E: sel = 3'(noc_pkg::PORT_E);
      noc_pkg::ARB_W: sel = 3'(noc_pkg::PORT_W);
      noc_pkg::ARB_S: sel = 3'(noc_pkg::PORT_S);
      default:        sel = 3'(noc_pkg::PORT_L);
    endcase
  end

  // current input first, then the ones after it, wrapping
  always_comb begin
    int p;
    state_next = noc_pkg::ARB_IDLE;
    for (int k = noc_pkg::NUM_PORTS - 1; k >= 0; k--) begin
      p = int'(sel) + k;
      if (p >= noc_pkg::NUM_PORTS) begin
        p = p - noc_pkg::NUM_PORTS;
      end
      if (req_in[p]) begin
        state_next = port_state(p);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // state and link handshake
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= noc_pkg::ARB_IDLE;
      tx_rts <= 1'b0;
    end else begin
      // frozen while waiting on the next router or while disabled
      if (enable && !(tx_rts && !tx_dcts)) begin
        state <= state_next;
      end
      if (tx_rts) begin
        tx_rts <= !tx_dcts;
      end else begin
        tx_rts <= enable && state != noc_pkg::ARB_IDLE && req_in[sel] && xb.valid[sel];
      end
    end
  end

  assign xfer    = tx_rts && tx_dcts;
  assign tx_flit = xb.head[sel];
  assign kind    = tx_flit[31:30];

  assign packet_done     = xfer && kind == noc_pkg::KIND_TAIL;
  assign xb.grant[PORT]  = xfer ? noc_pkg::port_mask_t'(1 << sel) : '0;

  // the flit comes from another unit's FIFO head
  a_tx_stable: assert property (@(posedge clk) disable iff (rst)
    (tx_rts && !tx_dcts) |=> (tx_rts && $stable(tx_flit)))
    else $error("output_arbiter: tx flit changed under back-pressure");

endmodule

`default_nettype wire

/* verilog/router_config.sv */
`timescale 1ns/1ps
`default_nettype none

module router_config (
  input  logic                clk,
  input  logic                rst,
  input  logic [1:0]          wb_adr,
  input  logic [31:0]         wb_dat_w,
  input  logic                wb_we,
  input  logic                wb_stb,
  input  logic                wb_cyc,
  input  noc_pkg::port_mask_t packet_done,
  output logic [31:0]         wb_dat_r,
  output logic                wb_ack,
  output noc_pkg::coord_t     local_x,
  output noc_pkg::coord_t     local_y,
  output noc_pkg::port_mask_t port_enable
);

  logic        access;
  logic        wr;
  logic [31:0] count;

  // new access only on the cycle after ack has dropped
  assign access = wb_cyc && wb_stb && !wb_ack;
  assign wr     = access && wb_we;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack      <= 1'b0;
      local_x     <= '0;
      local_y     <= '0;
      port_enable <= '1;
      count       <= '0;
    end else begin
      wb_ack <= access;
      if (wr && wb_adr == noc_pkg::REG_ADDR) begin
        local_x <= wb_dat_w[7:4];
        local_y <= wb_dat_w[3:0];
      end
      if (wr && wb_adr == noc_pkg::REG_ENABLE) begin
        port_enable <= wb_dat_w[4:0];
      end
      // several outputs can finish a packet in the same cycle
      if (wr && wb_adr == noc_pkg::REG_COUNT) begin
        count <= '0;
      end else begin
        count <= count + 32'($countones(packet_done));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (wb_adr)
        noc_pkg::REG_ADDR:   wb_dat_r <= {24'd0, local_x, local_y};
        noc_pkg::REG_ENABLE: wb_dat_r <= {27'd0, port_enable};
        noc_pkg::REG_COUNT:  wb_dat_r <= count;
        default:             wb_dat_r <= '0;
      endcase
    end
  end

  a_ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
    else $error("router_config: wb_ack held two cycles");

endmodule

`default_nettype wire

/* verilog/xbar_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface xbar_if;

  // one entry per input unit
  noc_pkg::flit_t      head [noc_pkg::NUM_PORTS];
  noc_pkg::port_mask_t valid;
  noc_pkg::port_mask_t req  [noc_pkg::NUM_PORTS];

  // one entry per output arbiter, bit i set when input i moves a flit
  noc_pkg::port_mask_t grant [noc_pkg::NUM_PORTS];

  modport in_side (
    output head,
    output valid,
    output req,
    input  grant
  );

  modport out_side (
    input  head,
    input  valid,
    input  req,
    output grant
  );

endinterface

`default_nettype wire
